/* design/zx_memio.sv */
// Memory paging and port top; RAM read data must be valid in the same cycle as the request
`timescale 1ns/10ps

module zx_memio
	import zx_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  machine_e   machine,
	input  logic [4:0] key_data,
	input  joy_t       joy,
	input  joy_mode_e  joy_mode,
	input  logic       tape_in,
	input  logic [7:0] ram_rdata,
	output ram_req_t   ram,
	output ula_out_t   ula,
	output logic [7:0] cpu_din
);

	logic       io_wr;
	logic       io_wr_q;
	logic       io_wr_pulse;
	logic [7:0] port_rdata;
	logic       port_hit;

	// ======================================================================
	// I/O write strobe edge
	// ======================================================================

	assign io_wr = bus.iorq & bus.wr & ~bus.m1;

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_wr_q <= 1'b0;
		else
			io_wr_q <= io_wr;
	end

	// One clock per bus write, however long the strobe stays high
	assign io_wr_pulse = io_wr & ~io_wr_q;

	zx_paging u_paging (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.machine     (machine),
		.io_wr_pulse (io_wr_pulse),
		.ram         (ram)
	);

	zx_port_io u_port_io (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.io_wr_pulse (io_wr_pulse),
		.key_data    (key_data),
		.joy         (joy),
		.joy_mode    (joy_mode),
		.tape_in     (tape_in),
		.ula         (ula),
		.port_rdata  (port_rdata),
		.port_hit    (port_hit)
	);

	// ======================================================================
	// CPU read data
	// ======================================================================

	// Undecoded ports float high
	assign cpu_din = bus.mreq ? ram_rdata :
		port_hit ? port_rdata : 8'hFF;

endmodule

/* design/zx_paging.sv */
// #7FFD/#1FFD paging for 48/128/+3 only; model is sampled while reset is high, no wait states
`timescale 1ns/10ps

module zx_paging
	import zx_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  cpu_bus_t bus,
	input  machine_e machine,
	input  logic     io_wr_pulse,
	output ram_req_t ram
);

	machine_e model;
	logic [7:0] page_reg;
	logic [7:0] page_reg_plus3;

	logic is_zx48;
	logic is_plus3;
	logic page_disable;
	logic page_special;
	logic active_48_rom;
	logic page_write;
	logic page_write_plus3;
	logic [3:0] rom_page;
	logic [1:0] slot;
	logic [2:0] bank;
	logic [11:0] special_map;
	logic map_rom;
	logic [RAM_ADDR_W-1:0] ram_addr;

	assign is_zx48  = (model == zx48);
	assign is_plus3 = (model == plus3);

	// 48 has no paging at all, bit 5 locks it until reset
	assign page_disable = is_zx48 | page_reg[5];
	assign page_special = page_reg_plus3[0];

	assign active_48_rom = is_zx48 | page_reg[4];

	// ======================================================================
	// Port decode
	// ======================================================================

	// #7FFD, partial decode; +3 also needs A14 so that #1FFD does not alias
	assign page_write = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_plus3) &
		~page_disable;

	assign page_write_plus3 = is_plus3 & (bus.addr[15:12] == 4'b0001) & ~bus.addr[1] &
		~page_disable;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model          <= machine;
			page_reg       <= 8'h00;
			page_reg_plus3 <= 8'h00;
		end else if (io_wr_pulse) begin
			if (page_write)
				page_reg <= bus.dout;
			else if (page_write_plus3)
				page_reg_plus3 <= bus.dout;
		end
	end

	// ======================================================================
	// Address mapping
	// ======================================================================

	// +3 has four ROMs, bit 0 of the non-+3 page is the 48 BASIC select
	assign rom_page = is_plus3 ? {2'b10, page_reg_plus3[2], page_reg[4]} :
		{is_zx48, 2'b11, active_48_rom};

	assign slot = bus.addr[15:14];

	// All-RAM layouts, slot 3 in the top field
	always_comb begin
		case (page_reg_plus3[2:1])
			2'b00:   special_map = {3'd3, 3'd2, 3'd1, 3'd0};
			2'b01:   special_map = {3'd7, 3'd6, 3'd5, 3'd4};
			2'b10:   special_map = {3'd3, 3'd6, 3'd5, 3'd4};
			default: special_map = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
	end

	always_comb begin
		map_rom = 1'b0;
		bank    = 3'd0;
		if (page_special) begin
			bank = special_map[slot * 3 +: 3];
		end else begin
			case (slot)
				2'b00:   map_rom = 1'b1;
				2'b01:   bank = 3'd5;
				2'b10:   bank = 3'd2;
				default: bank = page_reg[2:0];
			endcase
		end

		ram_addr = '0;
		ram_addr[PAGE_BITS-1:0] = bus.addr[PAGE_BITS-1:0];
		if (map_rom)
			ram_addr[PAGE_BITS +: 7] = {ROM_REGION, rom_page};
		else
			ram_addr[PAGE_BITS +: 3] = bank;
	end

	// ROM slot is write protected unless an all-RAM mode is on
	assign ram = '{
		addr: ram_addr,
		din:  bus.dout,
		we:   bus.mreq & bus.wr & (page_special | (slot != 2'b00)),
		rd:   bus.mreq & bus.rd
	};

endmodule

/* design/zx_pkg.sv */
// Shared bus types and memory map for the paging core; all bus levels are active high
package zx_pkg;

	// ======================================================================
	// Memory map constants
	// ======================================================================

	// External RAM address width, 32MB space
	localparam int RAM_ADDR_W = 25;

	// Upper address bits of the ROM area in external RAM
	localparam logic [2:0] ROM_REGION = 3'b101;

	// One 16K page
	localparam int PAGE_BITS = 14;

	// ======================================================================
	// Enumerations
	// ======================================================================

	typedef enum logic [1:0] {
		zx48  = 2'd0,
		zx128 = 2'd1,
		plus3 = 2'd2
	} machine_e;

	typedef enum logic [1:0] {
		kempston  = 2'd0,
		sinclair1 = 2'd1,
		cursor    = 2'd2
	} joy_mode_e;

	// ======================================================================
	// Bus and request structs
	// ======================================================================

	// One Z80 bus cycle, strobes already inverted to active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// Request towards external RAM
	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            din;
		logic                  we;
		logic                  rd;
	} ram_req_t;

	// ULA outputs from port #FE
	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_out_t;

	// One joystick, pressed is 1
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

endpackage

/* design/zx_port_io.sv */
// Port #FE and Kempston #1F only, partial decode like the original ULA; joystick is active high
`timescale 1ns/10ps

module zx_port_io
	import zx_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic       io_wr_pulse,
	input  logic [4:0] key_data,
	input  joy_t       joy,
	input  joy_mode_e  joy_mode,
	input  logic       tape_in,
	output ula_out_t   ula,
	output logic [7:0] port_rdata,
	output logic       port_hit
);

	logic       io_rd;
	logic       kemp_sel;
	logic       fe_sel;
	logic [7:0] kemp_dout;
	logic [4:0] joy_row12;
	logic [4:0] joy_row11;
	logic [4:0] joy_kbd;
	logic [4:0] kbd_dout;

	// ======================================================================
	// Port #FE write
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula.border <= 3'd0;
			ula.ear    <= 1'b0;
			ula.mic    <= 1'b0;
		end else if (io_wr_pulse && !bus.addr[0]) begin
			ula.border <= bus.dout[2:0];
			ula.mic    <= bus.dout[3];
			ula.ear    <= bus.dout[4];
		end
	end

	// ======================================================================
	// Joystick to keyboard
	// ======================================================================

	// Row 12 holds keys 0,9,8,7,6 from bit 0 up, row 11 holds 1..5
	always_comb begin
		joy_row12 = 5'b00000;
		joy_row11 = 5'b00000;
		case (joy_mode)
			sinclair1: begin
				joy_row12 = {joy.left, joy.right, joy.down, joy.up, joy.fire};
			end
			cursor: begin
				joy_row12 = {joy.down, joy.up, joy.right, 1'b0, joy.fire};
				// Left is key 5 on the other half row
				joy_row11 = {joy.left, 4'b0000};
			end
			default: begin
				joy_row12 = 5'b00000;
				joy_row11 = 5'b00000;
			end
		endcase
	end

	// Keys pull low only when their row is addressed
	assign joy_kbd = ({5{bus.addr[12]}} | ~joy_row12) & ({5{bus.addr[11]}} | ~joy_row11);
	assign kbd_dout = key_data & joy_kbd;

	// ======================================================================
	// Read decode
	// ======================================================================

	// Interrupt acknowledge also has iorq, so m1 is excluded
	assign io_rd = bus.iorq & bus.rd & ~bus.m1;

	assign kemp_sel = (bus.addr[5:0] == 6'h1F);
	assign fe_sel   = ~bus.addr[0] & ~kemp_sel;

	assign kemp_dout = (joy_mode == kempston) ?
		{3'b000, joy.fire, joy.up, joy.down, joy.left, joy.right} : 8'h00;

	assign port_rdata = kemp_sel ? kemp_dout : {1'b1, tape_in, 1'b1, kbd_dout};
	assign port_hit   = io_rd & (kemp_sel | fe_sel);

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f zx_memio.f --top-module zx_memio_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vzx_memio_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0

/* tests/zx_memio_patterns.txt */
# op addr data joy mode key tape, then expected ram_addr we cpu_din ula, all hex
# R reset (machine in data), W io write, I io read, M mem read, S mem write
R 0000 00 00 0 1F 0 0000000 0 00 00
M 0000 00 00 0 1F 0 017C000 0 5A 00
M 1234 00 00 0 1F 0 017D234 0 6E 00
M 4001 00 00 0 1F 0 0014001 0 5B 00
M 8002 00 00 0 1F 0 0008002 0 58 00
M C003 00 00 0 1F 0 0000003 0 59 00
W 7FFD 07 00 0 1F 0 0000000 0 FF 00
M C003 00 00 0 1F 0 0000003 0 59 00
W 00FE 1D 00 0 1F 0 0000000 0 FF 17
I 00FE 00 00 0 15 0 0000000 0 B5 17
S 0005 AA 00 0 1F 0 017C005 0 5F 17
S 4006 AA 00 0 1F 0 0014006 1 5C 17
# ZX 128
R 0000 01 00 0 1F 0 0000000 0 00 00
M 0000 00 00 0 1F 0 0158000 0 5A 00
W 7FFD 13 00 0 1F 0 0000000 0 FF 00
M 0100 00 00 0 1F 0 015C100 0 5A 00
M C010 00 00 0 1F 0 000C010 0 4A 00
W 7FFD 26 00 0 1F 0 0000000 0 FF 00
M C011 00 00 0 1F 0 0018011 0 4B 00
M 0000 00 00 0 1F 0 0158000 0 5A 00
W 7FFD 01 00 0 1F 0 0000000 0 FF 00
M C011 00 00 0 1F 0 0018011 0 4B 00
# +3 ROM pages and all-RAM modes
R 0000 02 00 0 1F 0 0000000 0 00 00
M 0000 00 00 0 1F 0 0160000 0 5A 00
W 7FFD 10 00 0 1F 0 0000000 0 FF 00
M 0000 00 00 0 1F 0 0164000 0 5A 00
W 1FFD 04 00 0 1F 0 0000000 0 FF 00
M 0000 00 00 0 1F 0 016C000 0 5A 00
M 2345 00 00 0 1F 0 016E345 0 1F 00
W 1FFD 01 00 0 1F 0 0000000 0 FF 00
M 0010 00 00 0 1F 0 0000010 0 4A 00
S 0011 77 00 0 1F 0 0000011 1 4B 00
M 4012 00 00 0 1F 0 0004012 0 48 00
M 8013 00 00 0 1F 0 0008013 0 49 00
M C014 00 00 0 1F 0 000C014 0 4E 00
W 1FFD 03 00 0 1F 0 0000000 0 FF 00
M 0020 00 00 0 1F 0 0010020 0 7A 00
M 4021 00 00 0 1F 0 0014021 0 7B 00
M 8022 00 00 0 1F 0 0018022 0 78 00
M C023 00 00 0 1F 0 001C023 0 79 00
W 1FFD 05 00 0 1F 0 0000000 0 FF 00
M 0031 00 00 0 1F 0 0010031 0 6B 00
M C030 00 00 0 1F 0 000C030 0 6A 00
W 1FFD 07 00 0 1F 0 0000000 0 FF 00
M 4040 00 00 0 1F 0 001C040 0 1A 00
M 8041 00 00 0 1F 0 0018041 0 1B 00
S 0042 55 00 0 1F 0 0010042 1 18 00
W 1FFD 00 00 0 1F 0 0000000 0 FF 00
S 0050 55 00 0 1F 0 0164050 0 0A 00
M C051 00 00 0 1F 0 0000051 0 0B 00
# Port FE and joysticks
W 00FE 0A 00 0 1F 0 0000000 0 FF 09
W 00FE 15 00 0 1F 0 0000000 0 FF 16
I 00FE 00 00 0 1F 1 0000000 0 FF 16
I 00FE 00 00 0 0A 0 0000000 0 AA 16
I EFFE 00 11 1 1F 0 0000000 0 B6 16
I F7FE 00 11 1 1F 0 0000000 0 BF 16
I EFFE 00 0E 1 1F 0 0000000 0 A9 16
I 001F 00 1F 1 1F 0 0000000 0 00 16
I EFFE 00 0A 2 1F 0 0000000 0 B7 16
I F7FE 00 0A 2 1F 0 0000000 0 AF 16
I E7FE 00 0A 2 1F 0 0000000 0 A7 16
I EFFE 00 15 2 1F 0 0000000 0 AA 16
I 001F 00 1F 0 1F 0 0000000 0 1F 16
I 001F 00 12 0 1F 0 0000000 0 12 16
I 00FE 00 1F 0 1F 0 0000000 0 BF 16
I 00FF 00 00 0 1F 0 0000000 0 FF 16
M 8077 00 00 0 1F 0 0008077 0 2D 16

/* tests/zx_memio_sva.sv */
// Bound into the zx_memio top and sees only its ports; assumes RAM banks stay below the ROM area
`timescale 1ns/10ps

module zx_memio_sva
	import zx_pkg::*;
(
	input logic     clk_sys,
	input logic     reset,
	input ula_out_t ula,
	input ram_req_t ram
);

	// ULA latch comes out of reset cleared
	property ula_clear_after_reset;
		@(posedge clk_sys) reset |=> (ula.border == 3'd0) && !ula.ear && !ula.mic;
	endproperty

	// Slot 00 maps to ROM only in the normal map, so no write may land there
	property rom_area_protected;
		@(posedge clk_sys) disable iff (reset)
			ram.we |-> (ram.addr[PAGE_BITS+4 +: 3] != ROM_REGION);
	endproperty

	a_ula_clear: assert property (ula_clear_after_reset)
		else $error("ULA outputs not cleared after reset");

	a_rom_protect: assert property (rom_area_protected)
		else $error("RAM write enable raised for the ROM area");

endmodule

bind zx_memio zx_memio_sva u_sva (
	.clk_sys (clk_sys),
	.reset   (reset),
	.ula     (ula),
	.ram     (ram)
);

/* tests/zx_memio_tb.sv */
// Pattern file path is relative to the project root, run stops at the first mismatch
`timescale 1ns/10ps

module zx_memio_tb
	import zx_pkg::*;
;

	localparam int HALF = 20;

	// One line of the pattern file
	typedef struct packed {
		logic [7:0]            op;
		logic [15:0]           addr;
		logic [7:0]            data;
		logic [4:0]            joy;
		logic [1:0]            mode;
		logic [4:0]            key;
		logic                  tape;
		logic [RAM_ADDR_W-1:0] exp_addr;
		logic                  exp_we;
		logic [7:0]            exp_din;
		logic [4:0]            exp_ula;
	} pattern_t;

	logic       clk_sys;
	logic       reset;
	cpu_bus_t   bus;
	machine_e   machine;
	logic [4:0] key_data;
	joy_t       joy;
	joy_mode_e  joy_mode;
	logic       tape_in;
	logic [7:0] ram_rdata;
	ram_req_t   ram;
	ula_out_t   ula;
	logic [7:0] cpu_din;

	pattern_t patterns[$];
	logic     loaded;
	int       timeout_cycles;

	// Memory model, read data tracks the low address byte
	assign ram_rdata = bus.addr[7:0] ^ 8'h5A;

	zx_memio u_zx_memio (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.machine   (machine),
		.key_data  (key_data),
		.joy       (joy),
		.joy_mode  (joy_mode),
		.tape_in   (tape_in),
		.ram_rdata (ram_rdata),
		.ram       (ram),
		.ula       (ula),
		.cpu_din   (cpu_din)
	);

	initial clk_sys = 1'b0;
	always #HALF clk_sys = ~clk_sys;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			stop_with_failure("Output mismatch");
		end
	endtask

	// ======================================================================
	// Pattern file reader
	// ======================================================================

	task automatic load_patterns();
		int fd;
		int code;
		logic [7:0]            op;
		logic [15:0]           addr;
		logic [7:0]            data;
		logic [4:0]            jv;
		logic [1:0]            mode;
		logic [4:0]            key;
		logic                  tape;
		logic [RAM_ADDR_W-1:0] e_addr;
		logic                  e_we;
		logic [7:0]            e_din;
		logic [4:0]            e_ula;
		logic [8*160-1:0]      rest;
		pattern_t              pat;
		fd = $fopen("tests/zx_memio_patterns.txt", "r");
		if (fd == 0)
			stop_with_failure("Cannot open tests/zx_memio_patterns.txt");
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", op);
			if (code != 1)
				break;
			if (op == "#") begin
				code = $fgets(rest, fd);
				continue;
			end
			if (op != "R" && op != "W" && op != "I" && op != "M" && op != "S")
				stop_with_failure("Unknown opcode in the pattern file");
			code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
				addr, data, jv, mode, key, tape, e_addr, e_we, e_din, e_ula);
			if (code != 10)
				stop_with_failure("Pattern line with missing columns");
			pat.op       = op;
			pat.addr     = addr;
			pat.data     = data;
			pat.joy      = jv;
			pat.mode     = mode;
			pat.key      = key;
			pat.tape     = tape;
			pat.exp_addr = e_addr;
			pat.exp_we   = e_we;
			pat.exp_din  = e_din;
			pat.exp_ula  = e_ula;
			patterns.push_back(pat);
		end
		$fclose(fd);
	endtask

	// ======================================================================
	// One pattern: bus for 2 cycles, then idle for 1
	// ======================================================================

	task automatic run_pattern(input pattern_t p);
		cpu_bus_t b;
		@(negedge clk_sys);
		if (p.op == "R") begin
			machine = machine_e'(p.data[1:0]);
			bus     = '0;
			reset   = 1'b1;
			repeat (3) @(negedge clk_sys);
			reset = 1'b0;
			#(HALF - 1);
			check_value("ula", 32'(ula), 32'(p.exp_ula));
		end else begin
			b      = '0;
			b.addr = p.addr;
			b.dout = p.data;
			case (p.op)
				"W": begin
					b.iorq = 1'b1;
					b.wr   = 1'b1;
				end
				"I": begin
					b.iorq = 1'b1;
					b.rd   = 1'b1;
				end
				"M": begin
					b.mreq = 1'b1;
					b.rd   = 1'b1;
				end
				default: begin
					b.mreq = 1'b1;
					b.wr   = 1'b1;
				end
			endcase
			bus      = b;
			joy      = p.joy;
			joy_mode = joy_mode_e'(p.mode);
			key_data = p.key;
			tape_in  = p.tape;
			#(HALF - 1);
			check_value("cpu_din", 32'(cpu_din), 32'(p.exp_din));
			check_value("ram.we", 32'(ram.we), 32'(p.exp_we));
			check_value("ram.rd", 32'(ram.rd), 32'(p.op == "M"));
			check_value("ram.din", 32'(ram.din), 32'(p.data));
			if (p.op == "M" || p.op == "S")
				check_value("ram.addr", 32'(ram.addr), 32'(p.exp_addr));
			@(negedge clk_sys);
			#(HALF - 1);
			check_value("ula", 32'(ula), 32'(p.exp_ula));
			@(negedge clk_sys);
			bus = '0;
			#(HALF - 1);
			check_value("idle ram.we", 32'(ram.we), 32'd0);
			check_value("idle ram.rd", 32'(ram.rd), 32'd0);
			check_value("idle cpu_din", 32'(cpu_din), 32'hFF);
		end
	endtask

	initial begin
		reset    = 1'b1;
		bus      = '0;
		machine  = zx48;
		key_data = 5'h1F;
		joy      = '0;
		joy_mode = kempston;
		tape_in  = 1'b0;
		loaded   = 1'b0;
		load_patterns();
		timeout_cycles = patterns.size() * 4 + 50;
		loaded = 1'b1;
		foreach (patterns[i])
			run_pattern(patterns[i]);
		$display("STATUS: PASS");
		$finish;
	end

	// Watchdog, four cycles per pattern line plus margin
	initial begin
		wait (loaded);
		repeat (timeout_cycles) @(posedge clk_sys);
		stop_with_failure("Watchdog expired before all patterns ran");
	end

endmodule

/* zx_memio.f */
design/zx_pkg.sv
design/zx_paging.sv
design/zx_port_io.sv
design/zx_memio.sv
tests/zx_memio_sva.sv
tests/zx_memio_tb.sv
